// File: all.f
uart_pkg.sv
max7219_pkg.sv
uart_rx.sv
cmd_decoder.sv
frame_ram.sv
display_sequencer.sv
max7219_serializer.sv
uart_max7219_display_ctrl.sv
tb_clk_gen.sv
tb_top.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --timescale 1ns/1ps --top-module tb_top -f all.f
out=$(./obj_dir/Vtb_top) || true
echo "$out"
echo "$out" | grep -q "TESTS PASSED"

// File: tb_top.sv
// ==============================
// Testbench for the UART to MAX7219 display controller
// Sends commands on the UART line and checks the frames on the MAX7219 pins
// ==============================
`timescale 1ns/1ps

module tb_top import uart_pkg::*; import max7219_pkg::*; ();

   localparam int CLKS_PER_BIT    = 16;
   localparam int NB_MATRIX       = 4;
   localparam int RAM_ADDR_WIDTH  = 8;
   localparam int MAX_HALF_PERIOD = 4;
   localparam int LOAD_DURATION   = 8;
   localparam int FRAME_BITS      = NB_MATRIX * MAX7219_WORD_BITS;
   // About 80 UART bytes of 160 clocks plus 24 words of 128 clocks, with margin
   localparam int TIMEOUT_CYCLES  = 60000;

   logic clk;
   logic rst_n;
   logic rx;
   logic max_load;
   logic max_data;
   logic max_clk;

   // Collected frames, one entry per load pulse
   logic [FRAME_BITS-1:0] frames [$];
   int                    frame_len [$];
   logic [FRAME_BITS-1:0] shift_bits = '0;
   int                    shift_cnt  = 0;

   // Expected RAM contents
   logic [15:0] model [2**RAM_ADDR_WIDTH];
   integer      seed;
   int          cycle_cnt = 0;

   tb_clk_gen tb_clk_gen_inst (
      .o_clk   (clk),
      .o_rst_n (rst_n)
   );

   uart_max7219_display_ctrl #(
      .CLKS_PER_BIT    (CLKS_PER_BIT),
      .NB_MATRIX       (NB_MATRIX),
      .RAM_ADDR_WIDTH  (RAM_ADDR_WIDTH),
      .MAX_HALF_PERIOD (MAX_HALF_PERIOD),
      .LOAD_DURATION   (LOAD_DURATION)
   ) uart_max7219_display_ctrl_inst (
      .clk            (clk),
      .i_rst_n        (rst_n),
      .i_rx           (rx),
      .o_max7219_load (max_load),
      .o_max7219_data (max_data),
      .o_max7219_clk  (max_clk)
   );

   // ==============================
   // MAX7219 pin monitor
   // ==============================
   // Clock and load never rise together, data is stable at the clock rise
   always @(posedge max_clk or posedge max_load) begin
      if (max_load) begin
         frames.push_back(shift_bits);
         frame_len.push_back(shift_cnt);
         shift_bits = '0;
         shift_cnt  = 0;
      end else begin
         shift_bits = {shift_bits[FRAME_BITS-2:0], max_data};
         shift_cnt++;
      end
   end

   // Run limit
   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("TESTS FAILED");
         $fatal(1, "Run stopped by timeout");
      end
   end

   task automatic check_eq(input logic [63:0] actual, input logic [63:0] expected,
                           input string what);
      if (actual !== expected) begin
         $display("ERR %0t ns: %s, got %0h, expected %0h", $time, what, actual, expected);
         $display("TESTS FAILED");
         $fatal(1, "Mismatch in %s", what);
      end
   endtask

   function automatic logic [15:0] rand_word();
      logic [31:0] r;
      r = $random(seed);
      return r[15:0];
   endfunction

   // ==============================
   // UART host side
   // ==============================
   // 8N1, LSB first, each bit held one bit time
   task automatic send_byte(input logic [7:0] b);
      logic [9:0] bits;
      bits = {1'b1, b, 1'b0};
      for (int i = 0; i < 10; i++) begin
         @(negedge clk);
         rx = bits[i];
         repeat (CLKS_PER_BIT - 1) @(negedge clk);
      end
   endtask

   // Sequencer is already busy when the last byte's stop bit ends
   task automatic wait_seq_done();
      while (!uart_max7219_display_ctrl_inst.seq_busy) @(negedge clk);
      while (uart_max7219_display_ctrl_inst.seq_busy) @(negedge clk);
   endtask

   task automatic cfg_cmd(input logic [3:0] reg_addr, input logic [7:0] data);
      send_byte(CMD_CFG);
      send_byte({4'h0, reg_addr});
      send_byte(data);
      wait_seq_done();
   endtask

   task automatic write_word(input logic [7:0] addr, input logic [15:0] data);
      send_byte(CMD_WR);
      send_byte(addr);
      send_byte(data[15:8]);
      send_byte(data[7:0]);
      model[addr] = data;
   endtask

   task automatic show_cmd(input logic [7:0] addr, input logic [7:0] loads);
      send_byte(CMD_SHOW);
      send_byte(addr);
      send_byte(loads);
      wait_seq_done();
   endtask

   // First word sent ends up in the top bits, address wraps at 8 bits
   function automatic logic [FRAME_BITS-1:0] expected_frame(input logic [7:0] start);
      logic [FRAME_BITS-1:0] f;
      logic [7:0]            a;
      f = '0;
      a = start;
      for (int i = 0; i < NB_MATRIX; i++) begin
         f = {f[FRAME_BITS-MAX7219_WORD_BITS-1:0], model[a]};
         a = a + 8'd1;
      end
      return f;
   endfunction

   // Frame count and length of every frame
   task automatic check_frames(input int count);
      check_eq(64'(frames.size()), 64'(count), "number of loads");
      foreach (frame_len[i])
         check_eq(64'(frame_len[i]), 64'(FRAME_BITS), "bits per load");
   endtask

   task automatic check_cfg_frame(input logic [FRAME_BITS-1:0] f,
                                  input logic [3:0] reg_addr, input logic [7:0] data);
      logic [15:0] w;
      for (int i = 0; i < NB_MATRIX; i++) begin
         w = f[FRAME_BITS-1-MAX7219_WORD_BITS*i -: MAX7219_WORD_BITS];
         check_eq(64'(w[11:8]), 64'(reg_addr), "config word register");
         check_eq(64'(w[7:0]), 64'(data), "config word data");
      end
   endtask

   // ==============================
   // Tests
   // ==============================
   task automatic test_reset();
      repeat (20) begin
         @(negedge clk);
         check_eq(64'(max_clk), 64'd0, "MAX7219 clock after reset");
         check_eq(64'(max_data), 64'd0, "MAX7219 data after reset");
         check_eq(64'(max_load), 64'd0, "MAX7219 load after reset");
      end
      check_frames(0);
   endtask

   task automatic test_cfg_intensity();
      frames.delete();
      frame_len.delete();
      cfg_cmd(REG_INTENSITY, 8'h0A);
      check_frames(1);
      check_cfg_frame(frames[0], 4'hA, 8'h0A);
   endtask

   task automatic test_show_one_load();
      frames.delete();
      frame_len.delete();
      for (int i = 0; i < 4; i++)
         write_word(8'h10 + 8'(i), rand_word());
      show_cmd(8'h10, 8'd1);
      check_frames(1);
      check_eq(frames[0], expected_frame(8'h10), "one-load frame");
   endtask

   task automatic test_show_two_loads();
      frames.delete();
      frame_len.delete();
      for (int i = 0; i < 8; i++)
         write_word(8'h20 + 8'(i), rand_word());
      show_cmd(8'h20, 8'd2);
      check_frames(2);
      check_eq(frames[0], expected_frame(8'h20), "first frame of two");
      check_eq(frames[1], expected_frame(8'h24), "second frame of two");
   endtask

   // Run crosses the top of the RAM
   task automatic test_show_wrap();
      frames.delete();
      frame_len.delete();
      for (int i = 0; i < 4; i++)
         write_word(8'hFE + 8'(i), rand_word());
      show_cmd(8'hFE, 8'd1);
      check_frames(1);
      check_eq(frames[0], expected_frame(8'hFE), "wrapped frame");
   endtask

   task automatic test_unknown_cmd();
      frames.delete();
      frame_len.delete();
      send_byte(8'h7F);
      cfg_cmd(REG_SHUTDOWN, 8'h01);
      check_frames(1);
      check_cfg_frame(frames[0], 4'hC, 8'h01);
   endtask

   initial begin
      rx   = 1'b1;
      seed = 32'hcfc4;
      wait (rst_n === 1'b1);
      test_reset();
      test_cfg_intensity();
      test_show_one_load();
      test_show_two_loads();
      test_show_wrap();
      test_unknown_cmd();
      $display("TESTS PASSED");
      $finish;
   end

endmodule

// File: tb_clk_gen.sv
// ==============================
// Testbench clock and reset
// 100 ns clock, reset low for the first cycles
// ==============================
`timescale 1ns/1ps

module tb_clk_gen #(
   parameter int HALF_PERIOD_NS = 50,
   parameter int RESET_CYCLES   = 5
) (
   output logic o_clk,
   output logic o_rst_n
);

   // Free-running clock
   initial begin
      o_clk = 1'b0;
      forever #(HALF_PERIOD_NS) o_clk = ~o_clk;
   end

   // Reset released on a falling edge, away from the DUT sampling edge
   initial begin
      o_rst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge o_clk);
      @(negedge o_clk);
      o_rst_n = 1'b1;
   end

endmodule

// File: uart_max7219_display_ctrl.sv
// ============================
// UART to MAX7219 display controller
// Sets the parameters and wires the blocks
// ============================
`timescale 1ns/1ps

module uart_max7219_display_ctrl import max7219_pkg::*; #(
   parameter int CLKS_PER_BIT    = 16,
   parameter int NB_MATRIX       = 4,
   parameter int RAM_ADDR_WIDTH  = 8,
   parameter int MAX_HALF_PERIOD = 4,
   parameter int LOAD_DURATION   = 8
) (
   input  logic clk,
   input  logic i_rst_n,
   input  logic i_rx,
   output logic o_max7219_load,
   output logic o_max7219_data,
   output logic o_max7219_clk
);

   // UART to decoder
   logic [7:0]                   rx_byte;
   logic                         rx_strobe;

   // Decoder to RAM and sequencer
   logic                         ram_we;
   logic [RAM_ADDR_WIDTH-1:0]    ram_waddr;
   logic [MAX7219_WORD_BITS-1:0] ram_wdata;
   logic                         cfg_start;
   logic [3:0]                   cfg_reg;
   logic [7:0]                   cfg_data;
   logic                         show_start;
   logic [RAM_ADDR_WIDTH-1:0]    show_addr;
   logic [7:0]                   show_loads;
   logic                         seq_busy;

   // Sequencer to RAM read port and serializer
   logic [RAM_ADDR_WIDTH-1:0]    ram_raddr;
   logic [MAX7219_WORD_BITS-1:0] ram_rdata;
   logic                         word_strobe;
   max7219_word_u                word;
   logic                         word_last;
   logic                         word_done;

   uart_rx #(
      .CLKS_PER_BIT (CLKS_PER_BIT)
   ) uart_rx_inst (
      .clk      (clk),
      .i_rst_n  (i_rst_n),
      .i_rx     (i_rx),
      .o_byte   (rx_byte),
      .o_strobe (rx_strobe)
   );

   cmd_decoder #(
      .RAM_ADDR_WIDTH (RAM_ADDR_WIDTH)
   ) cmd_decoder_inst (
      .clk          (clk),
      .i_rst_n      (i_rst_n),
      .i_byte       (rx_byte),
      .i_strobe     (rx_strobe),
      .i_seq_busy   (seq_busy),
      .o_ram_we     (ram_we),
      .o_ram_waddr  (ram_waddr),
      .o_ram_wdata  (ram_wdata),
      .o_cfg_start  (cfg_start),
      .o_cfg_reg    (cfg_reg),
      .o_cfg_data   (cfg_data),
      .o_show_start (show_start),
      .o_show_addr  (show_addr),
      .o_show_loads (show_loads)
   );

   frame_ram #(
      .RAM_ADDR_WIDTH (RAM_ADDR_WIDTH)
   ) frame_ram_inst (
      .clk     (clk),
      .i_we    (ram_we),
      .i_waddr (ram_waddr),
      .i_wdata (ram_wdata),
      .i_raddr (ram_raddr),
      .o_rdata (ram_rdata)
   );

   display_sequencer #(
      .NB_MATRIX      (NB_MATRIX),
      .RAM_ADDR_WIDTH (RAM_ADDR_WIDTH)
   ) display_sequencer_inst (
      .clk           (clk),
      .i_rst_n       (i_rst_n),
      .i_cfg_start   (cfg_start),
      .i_cfg_reg     (cfg_reg),
      .i_cfg_data    (cfg_data),
      .i_show_start  (show_start),
      .i_show_addr   (show_addr),
      .i_show_loads  (show_loads),
      .o_busy        (seq_busy),
      .o_ram_raddr   (ram_raddr),
      .i_ram_rdata   (ram_rdata),
      .o_word_strobe (word_strobe),
      .o_word        (word),
      .o_word_last   (word_last),
      .i_word_done   (word_done)
   );

   max7219_serializer #(
      .MAX_HALF_PERIOD (MAX_HALF_PERIOD),
      .LOAD_DURATION   (LOAD_DURATION)
   ) max7219_serializer_inst (
      .clk            (clk),
      .i_rst_n        (i_rst_n),
      .i_word_strobe  (word_strobe),
      .i_word         (word),
      .i_word_last    (word_last),
      .o_word_done    (word_done),
      .o_max7219_clk  (o_max7219_clk),
      .o_max7219_data (o_max7219_data),
      .o_max7219_load (o_max7219_load)
   );

endmodule

// File: max7219_serializer.sv
// ============================
// MAX7219 serializer
// Shifts a word MSB first and pulses load
// after the last word of a frame
// ============================
`timescale 1ns/1ps

module max7219_serializer import max7219_pkg::*; #(
   parameter int MAX_HALF_PERIOD = 4,
   parameter int LOAD_DURATION   = 8
) (
   input  logic          clk,
   input  logic          i_rst_n,
   input  logic          i_word_strobe,
   input  max7219_word_u i_word,
   input  logic          i_word_last,
   output logic          o_word_done,
   output logic          o_max7219_clk,
   output logic          o_max7219_data,
   output logic          o_max7219_load
);

   localparam int CNT_MAX = (MAX_HALF_PERIOD > LOAD_DURATION) ? MAX_HALF_PERIOD
                                                              : LOAD_DURATION;
   localparam int CNT_W   = $clog2(CNT_MAX + 1);
   localparam int BIT_W   = $clog2(MAX7219_WORD_BITS);

   localparam logic [1:0] SR_IDLE  = 2'd0;
   localparam logic [1:0] SR_SHIFT = 2'd1;
   localparam logic [1:0] SR_LOAD  = 2'd2;

   logic [1:0]                   state;
   logic [CNT_W-1:0]             cnt;
   logic [BIT_W-1:0]             bit_cnt;
   logic [MAX7219_WORD_BITS-1:0] shreg;
   logic                         last_r;
   logic                         hp_end;
   logic                         fall;

   assign hp_end = (cnt == CNT_W'(MAX_HALF_PERIOD - 1));
   // Clock about to go low, the only point where data moves
   assign fall   = (state == SR_SHIFT) && hp_end && o_max7219_clk;

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         state          <= SR_IDLE;
         cnt            <= '0;
         bit_cnt        <= '0;
         last_r         <= 1'b0;
         o_word_done    <= 1'b0;
         o_max7219_clk  <= 1'b0;
         o_max7219_data <= 1'b0;
         o_max7219_load <= 1'b0;
      end else begin
         o_word_done <= 1'b0;
         case (state)
            SR_IDLE: if (i_word_strobe) begin
               state          <= SR_SHIFT;
               cnt            <= '0;
               bit_cnt        <= '0;
               last_r         <= i_word_last;
               o_max7219_data <= i_word.raw[MAX7219_WORD_BITS-1];
            end
            SR_SHIFT: if (!hp_end) begin
               cnt <= cnt + 1'b1;
            end else begin
               cnt           <= '0;
               o_max7219_clk <= ~o_max7219_clk;
               if (fall && bit_cnt == BIT_W'(MAX7219_WORD_BITS - 1)) begin
                  o_max7219_data <= 1'b0;
                  // Load only closes a frame
                  if (last_r) begin
                     o_max7219_load <= 1'b1;
                     state          <= SR_LOAD;
                  end else begin
                     o_word_done <= 1'b1;
                     state       <= SR_IDLE;
                  end
               end else if (fall) begin
                  bit_cnt        <= bit_cnt + 1'b1;
                  o_max7219_data <= shreg[MAX7219_WORD_BITS-2];
               end
            end
            default: if (cnt == CNT_W'(LOAD_DURATION - 1)) begin
               cnt            <= '0;
               o_max7219_load <= 1'b0;
               o_word_done    <= 1'b1;
               state          <= SR_IDLE;
            end else begin
               cnt <= cnt + 1'b1;
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == SR_IDLE && i_word_strobe) shreg <= i_word.raw;
      else if (fall) shreg <= {shreg[MAX7219_WORD_BITS-2:0], 1'b0};
   end

endmodule

// File: display_sequencer.sv
// ============================
// Display sequencer
// Sends config words to the whole chain and
// streams RAM runs to the serializer
// ============================
`timescale 1ns/1ps

module display_sequencer import uart_pkg::*; import max7219_pkg::*; #(
   parameter int NB_MATRIX      = 4,
   parameter int RAM_ADDR_WIDTH = 8
) (
   input  logic                         clk,
   input  logic                         i_rst_n,
   input  logic                         i_cfg_start,
   input  logic [3:0]                   i_cfg_reg,
   input  logic [7:0]                   i_cfg_data,
   input  logic                         i_show_start,
   input  logic [RAM_ADDR_WIDTH-1:0]    i_show_addr,
   input  logic [7:0]                   i_show_loads,
   output logic                         o_busy,
   output logic [RAM_ADDR_WIDTH-1:0]    o_ram_raddr,
   input  logic [MAX7219_WORD_BITS-1:0] i_ram_rdata,
   output logic                         o_word_strobe,
   output max7219_word_u                o_word,
   output logic                         o_word_last,
   input  logic                         i_word_done
);

   localparam int MAT_W = (NB_MATRIX > 1) ? $clog2(NB_MATRIX) : 1;

   localparam logic [1:0] SQ_IDLE  = 2'd0;
   localparam logic [1:0] SQ_FETCH = 2'd1;
   localparam logic [1:0] SQ_SEND  = 2'd2;
   localparam logic [1:0] SQ_WAIT  = 2'd3;

   logic [1:0]                state;
   cmd_t                      mode;
   logic [MAT_W-1:0]          mat_idx;
   logic [7:0]                loads_left;
   logic [RAM_ADDR_WIDTH-1:0] rd_addr;
   logic                      load_end;

   assign o_busy      = (state != SQ_IDLE);
   assign o_ram_raddr = rd_addr;
   // Last word of the chain closes the load
   assign load_end    = (mat_idx == MAT_W'(NB_MATRIX - 1));

   // ============================
   // Sequencing FSM
   // ============================
   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         state         <= SQ_IDLE;
         mode          <= CMD_CFG;
         mat_idx       <= '0;
         loads_left    <= '0;
         rd_addr       <= '0;
         o_word_strobe <= 1'b0;
         o_word_last   <= 1'b0;
      end else begin
         o_word_strobe <= 1'b0;
         case (state)
            SQ_IDLE: begin
               mat_idx <= '0;
               // Config is a single load of identical words
               if (i_cfg_start) begin
                  mode       <= CMD_CFG;
                  loads_left <= 8'd1;
                  state      <= SQ_SEND;
               end else if (i_show_start && i_show_loads != 8'd0) begin
                  mode       <= CMD_SHOW;
                  loads_left <= i_show_loads;
                  rd_addr    <= i_show_addr;
                  state      <= SQ_FETCH;
               end
            end
            // RAM read in flight
            SQ_FETCH: state <= SQ_SEND;
            SQ_SEND: begin
               o_word_strobe <= 1'b1;
               o_word_last   <= load_end;
               state         <= SQ_WAIT;
            end
            default: if (i_word_done) begin
               if (o_word_last) begin
                  mat_idx    <= '0;
                  loads_left <= loads_left - 8'd1;
               end else begin
                  mat_idx <= mat_idx + 1'b1;
               end
               if (o_word_last && loads_left == 8'd1) begin
                  state <= SQ_IDLE;
               end else if (mode == CMD_CFG) begin
                  state <= SQ_SEND;
               end else begin
                  // Wraps at the top of the RAM
                  rd_addr <= rd_addr + 1'b1;
                  state   <= SQ_FETCH;
               end
            end
         endcase
      end
   end

   // Word register, config through the field view
   always_ff @(posedge clk) begin
      if (state == SQ_IDLE && i_cfg_start) begin
         o_word.f.dont_care <= 4'h0;
         o_word.f.addr      <= i_cfg_reg;
         o_word.f.data      <= i_cfg_data;
      end else if (state == SQ_SEND && mode == CMD_SHOW) begin
         o_word.raw <= i_ram_rdata;
      end
   end

   // Serializer is only fed inside a command
   a_strobe_busy : assert property (@(posedge clk) disable iff (!i_rst_n)
      o_word_strobe |-> o_busy);

endmodule

// File: frame_ram.sv
// ============================
// Frame RAM
// One write port, one registered read port
// ============================
`timescale 1ns/1ps

module frame_ram import max7219_pkg::*; #(
   parameter int RAM_ADDR_WIDTH = 8
) (
   input  logic                         clk,
   input  logic                         i_we,
   input  logic [RAM_ADDR_WIDTH-1:0]    i_waddr,
   input  logic [MAX7219_WORD_BITS-1:0] i_wdata,
   input  logic [RAM_ADDR_WIDTH-1:0]    i_raddr,
   output logic [MAX7219_WORD_BITS-1:0] o_rdata
);

   logic [MAX7219_WORD_BITS-1:0] mem [2**RAM_ADDR_WIDTH];

   always_ff @(posedge clk) begin
      if (i_we) mem[i_waddr] <= i_wdata;
   end

   // Read data one cycle after the address
   always_ff @(posedge clk) begin
      o_rdata <= mem[i_raddr];
   end

endmodule

// File: cmd_decoder.sv
// ============================
// Command decoder
// Collects command payload bytes and issues RAM
// writes and sequencer requests
// ============================
`timescale 1ns/1ps

module cmd_decoder import uart_pkg::*; import max7219_pkg::*; #(
   parameter int RAM_ADDR_WIDTH = 8
) (
   input  logic                         clk,
   input  logic                         i_rst_n,
   input  logic [UART_DATA_BITS-1:0]    i_byte,
   input  logic                         i_strobe,
   input  logic                         i_seq_busy,
   output logic                         o_ram_we,
   output logic [RAM_ADDR_WIDTH-1:0]    o_ram_waddr,
   output logic [MAX7219_WORD_BITS-1:0] o_ram_wdata,
   output logic                         o_cfg_start,
   output logic [3:0]                   o_cfg_reg,
   output logic [7:0]                   o_cfg_data,
   output logic                         o_show_start,
   output logic [RAM_ADDR_WIDTH-1:0]    o_show_addr,
   output logic [7:0]                   o_show_loads
);

   // Command byte, then up to three payload bytes
   localparam logic [1:0] ST_CMD = 2'd0;
   localparam logic [1:0] ST_P0  = 2'd1;
   localparam logic [1:0] ST_P1  = 2'd2;
   localparam logic [1:0] ST_P2  = 2'd3;

   logic [1:0]                state;
   cmd_t                      cmd;
   logic [UART_DATA_BITS-1:0] byte0;
   logic [UART_DATA_BITS-1:0] byte1;
   logic                      accept;
   logic                      last_byte;

   // No back-pressure, bytes seen while busy are lost
   assign accept = i_strobe && !i_seq_busy;

   // WR carries three payload bytes, CFG and SHOW two
   always_comb begin
      case (cmd)
         CMD_WR:  last_byte = (state == ST_P2);
         default: last_byte = (state == ST_P1);
      endcase
   end

   // ============================
   // Control FSM
   // ============================
   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         state        <= ST_CMD;
         cmd          <= CMD_CFG;
         o_ram_we     <= 1'b0;
         o_cfg_start  <= 1'b0;
         o_show_start <= 1'b0;
      end else begin
         o_ram_we     <= 1'b0;
         o_cfg_start  <= 1'b0;
         o_show_start <= 1'b0;
         if (accept) begin
            if (state == ST_CMD) begin
               case (i_byte)
                  CMD_CFG, CMD_WR, CMD_SHOW: begin
                     cmd   <= cmd_t'(i_byte);
                     state <= ST_P0;
                  end
                  // Unknown codes are skipped
                  default: state <= ST_CMD;
               endcase
            end else if (last_byte) begin
               state        <= ST_CMD;
               o_ram_we     <= (cmd == CMD_WR);
               o_cfg_start  <= (cmd == CMD_CFG);
               o_show_start <= (cmd == CMD_SHOW);
            end else begin
               state <= state + 2'd1;
            end
         end
      end
   end

   // Payload capture, outputs settle with the pulse
   always_ff @(posedge clk) begin
      if (accept) begin
         if (state == ST_P0) byte0 <= i_byte;
         if (state == ST_P1) byte1 <= i_byte;
         if (last_byte) begin
            o_ram_waddr  <= byte0[RAM_ADDR_WIDTH-1:0];
            o_ram_wdata  <= {byte1, i_byte};
            o_cfg_reg    <= byte0[3:0];
            o_cfg_data   <= i_byte;
            o_show_addr  <= byte0[RAM_ADDR_WIDTH-1:0];
            o_show_loads <= i_byte;
         end
      end
   end

   // One request per command
   a_one_start : assert property (@(posedge clk) disable iff (!i_rst_n)
      !(o_cfg_start && o_show_start));

endmodule

// File: uart_rx.sv
// ============================
// UART receiver, 8N1
// Samples each bit at mid-bit and strobes
// every byte with a valid stop bit
// ============================
`timescale 1ns/1ps

module uart_rx import uart_pkg::*; #(
   parameter int CLKS_PER_BIT = 16
) (
   input  logic                      clk,
   input  logic                      i_rst_n,
   input  logic                      i_rx,
   output logic [UART_DATA_BITS-1:0] o_byte,
   output logic                      o_strobe
);

   localparam int CNT_W = $clog2(CLKS_PER_BIT);
   localparam int BIT_W = $clog2(UART_DATA_BITS);

   localparam logic [1:0] RX_IDLE  = 2'd0;
   localparam logic [1:0] RX_START = 2'd1;
   localparam logic [1:0] RX_DATA  = 2'd2;
   localparam logic [1:0] RX_STOP  = 2'd3;

   logic [1:0]                state;
   logic [1:0]                rx_sync;
   logic [CNT_W-1:0]          clk_cnt;
   logic [BIT_W-1:0]          bit_idx;
   logic [UART_DATA_BITS-1:0] shreg;
   logic                      bit_end;
   logic                      half_end;

   // Line idles high
   always_ff @(posedge clk) begin
      if (!i_rst_n) rx_sync <= 2'b11;
      else          rx_sync <= {rx_sync[0], i_rx};
   end

   assign bit_end  = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));
   assign half_end = (clk_cnt == CNT_W'(CLKS_PER_BIT / 2 - 1));

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         state    <= RX_IDLE;
         clk_cnt  <= '0;
         bit_idx  <= '0;
         o_strobe <= 1'b0;
      end else begin
         o_strobe <= 1'b0;
         clk_cnt  <= clk_cnt + 1'b1;
         case (state)
            RX_IDLE: begin
               clk_cnt <= '0;
               if (!rx_sync[1]) state <= RX_START;
            end
            // Recheck the start bit at its middle, glitches go back to idle
            RX_START: if (half_end) begin
               clk_cnt <= '0;
               bit_idx <= '0;
               state   <= rx_sync[1] ? RX_IDLE : RX_DATA;
            end
            RX_DATA: if (bit_end) begin
               clk_cnt <= '0;
               bit_idx <= bit_idx + 1'b1;
               if (bit_idx == BIT_W'(UART_DATA_BITS - 1)) state <= RX_STOP;
            end
            // Framing error drops the byte
            default: if (bit_end) begin
               o_strobe <= rx_sync[1];
               state    <= RX_IDLE;
            end
         endcase
      end
   end

   // LSB first
   always_ff @(posedge clk) begin
      if (state == RX_DATA && bit_end) shreg <= {rx_sync[1], shreg[UART_DATA_BITS-1:1]};
   end

   assign o_byte = shreg;

   // Strobe is single-cycle, bytes are a full frame apart
   a_strobe_pulse : assert property (@(posedge clk) disable iff (!i_rst_n)
      o_strobe |=> !o_strobe);

endmodule

// File: max7219_pkg.sv
// ============================
// MAX7219 package
// Register map and the 16-bit frame word
// ============================
package max7219_pkg;

   // Register addresses, upper nibble of the word is ignored by the chip
   localparam logic [3:0] REG_NOOP         = 4'h0;
   localparam logic [3:0] REG_DIGIT0       = 4'h1;
   localparam logic [3:0] REG_DECODE_MODE  = 4'h9;
   localparam logic [3:0] REG_INTENSITY    = 4'hA;
   localparam logic [3:0] REG_SCAN_LIMIT   = 4'hB;
   localparam logic [3:0] REG_SHUTDOWN     = 4'hC;
   localparam logic [3:0] REG_DISPLAY_TEST = 4'hF;

   // Bits shifted per word
   localparam int MAX7219_WORD_BITS = 16;

   // Frame word, raw for storage and shifting, fields for composing
   typedef union packed {
      logic [MAX7219_WORD_BITS-1:0] raw;
      struct packed {
         logic [3:0] dont_care;
         logic [3:0] addr;
         logic [7:0] data;
      } f;
   } max7219_word_u;

endpackage

// File: uart_pkg.sv
// ============================
// UART package
// Framing width and command codes
// of the host byte protocol
// ============================
package uart_pkg;

   // 8N1 framing, data bits per character
   localparam int UART_DATA_BITS = 8;

   // ============================
   // Command codes
   // ============================
   // CFG  payload: register, data
   // WR   payload: address, word high, word low
   // SHOW payload: start address, load count
   typedef enum logic [7:0] {
      CMD_CFG  = 8'h01,
      CMD_WR   = 8'h02,
      CMD_SHOW = 8'h03
   } cmd_t;

endpackage
